// File: logic/fetch_geom_pkg.sv
////////////////////////////////////////////////////////////////////////////
// cache geometry and address layout for the instruction fetch front end
// imported by every RTL module and by the testbench memory model
// a fetch block is 64 bits wide and holds two 32-bit instructions
////////////////////////////////////////////////////////////////////////////

package fetch_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////////////////////

	// byte address and fetch block
	localparam int addr_bits = 32;
	localparam int block_bits = 64;

	// offset within one block, 8 bytes
	localparam int offset_bits = 3;
	// direct mapped, one block per line
	localparam int index_bits = 5;
	localparam int tag_bits = 8;

	// field positions in a byte address
	localparam int index_lsb = offset_bits;
	localparam int tag_lsb = offset_bits + index_bits;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [addr_bits-1:0] addr_t;
	typedef logic [block_bits-1:0] block_t;
	// address bits 7:3
	typedef logic [index_bits-1:0] line_index_t;
	// address bits 15:8
	typedef logic [tag_bits-1:0] line_tag_t;

	// number of cache lines
	localparam int num_lines = 1 << index_bits;
	// pc step per accepted block
	localparam addr_t block_bytes = 32'd8;
	// first fetch address out of reset
	localparam addr_t reset_pc = 32'h0000_0000;

endpackage

// File: logic/mem_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// memory bus protocol between the miss controller and main memory
// command out, tag handshake back, data returned later under that tag
////////////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// command encoding
	////////////////////////////////////////////////////////////////////////////

	// only loads exist on this side of the core
	typedef enum logic [1:0] {
		cmd_none = 2'h0,
		cmd_load = 2'h1
	} mem_cmd_t;

	////////////////////////////////////////////////////////////////////////////
	// transaction tags
	////////////////////////////////////////////////////////////////////////////

	localparam int tag_bits = 4;

	// response and returning tag share one width
	typedef logic [tag_bits-1:0] mem_tag_t;

	// zero response means the load was refused,
	// zero returning tag means no data this cycle
	localparam mem_tag_t no_tag = '0;

endpackage

// File: logic/fetch_pc_counter.sv
////////////////////////////////////////////////////////////////////////////
// fetch program counter
// steps one block per accepted hit, holds on stall or miss, and loads an
// aligned target on redirect, which wins over stall
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_pc_counter (
	input logic clock,
	input logic reset,
	// lookup hit for the current pc
	input logic hit,
	// back end full
	input logic stall,
	// flush from the back end
	input logic redirect,
	input fetch_geom_pkg::addr_t redirect_pc,
	output fetch_geom_pkg::addr_t pc
);

	import fetch_geom_pkg::*;

	// redirect target with the byte offset dropped
	addr_t aligned_target;
	// block was handed to the consumer this cycle
	logic accept;

	assign aligned_target = {redirect_pc[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
	assign accept = hit && !stall;

	////////////////////////////////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (redirect) begin
			// redirect wins even over a stalled hit
			pc <= aligned_target;
		end else if (accept) begin
			pc <= pc + block_bytes;
		end
		// miss or stall, hold
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// pc never leaves a block boundary, whatever the redirect source sends
	pc_aligned: assert property (
		@(posedge clock) disable iff (reset)
		pc[offset_bits-1:0] == '0
	) else $error("fetch pc %h not block aligned", pc);

endmodule

// File: logic/icache_lines.sv
////////////////////////////////////////////////////////////////////////////
// direct mapped instruction cache storage
// combinational lookup port for the fetch pc, clocked fill port from the
// miss controller; a fill evicts whatever line sits at its index
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_lines (
	input logic clock,
	input logic reset,
	// read side
	input fetch_geom_pkg::addr_t lookup_addr,
	// write side
	input logic fill_en,
	input fetch_geom_pkg::addr_t fill_addr,
	input fetch_geom_pkg::block_t fill_block,
	output logic hit,
	output fetch_geom_pkg::block_t lookup_block
);

	import fetch_geom_pkg::*;

	// line storage
	block_t data_mem [num_lines];
	line_tag_t tag_mem [num_lines];
	logic [num_lines-1:0] valid_bits;

	// address fields
	line_index_t lookup_index;
	line_tag_t lookup_tag;
	line_index_t fill_index;
	line_tag_t fill_tag;

	assign lookup_index = lookup_addr[index_lsb +: index_bits];
	assign lookup_tag = lookup_addr[tag_lsb +: tag_bits];
	assign fill_index = fill_addr[index_lsb +: index_bits];
	assign fill_tag = fill_addr[tag_lsb +: tag_bits];

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////

	// valid and tag compare, same cycle as the address
	assign hit = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	// data shown even on a miss, hit qualifies it
	assign lookup_block = data_mem[lookup_index];

	////////////////////////////////////////////////////////////////////////////
	// fill
	////////////////////////////////////////////////////////////////////////////

	// valid bits are the only control state here
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (fill_en) begin
			valid_bits[fill_index] <= 1'b1;
		end
	end

	// tag and data replaced together
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tag_mem[fill_index] <= fill_tag;
			data_mem[fill_index] <= fill_block;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// the miss controller must come out of reset quiet,
	// or a stale tag match would write a line before valid bits clear
	no_fill_in_reset: assert property (
		@(posedge clock)
		reset |-> !fill_en
	) else $error("cache fill during reset");

endmodule

// File: logic/icache_miss_fsm.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache miss controller
// issues one load per miss, retries while memory refuses, then waits for
// the returning tag and raises the fill; one miss outstanding at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_miss_fsm (
	input logic clock,
	input logic reset,
	// current fetch address and its lookup result
	input fetch_geom_pkg::addr_t lookup_addr,
	input logic hit,
	input logic redirect,
	// memory handshake
	input mem_bus_pkg::mem_tag_t mem_response,
	input mem_bus_pkg::mem_tag_t mem_tag,
	output mem_bus_pkg::mem_cmd_t mem_command,
	output fetch_geom_pkg::addr_t mem_addr,
	// cache write port
	output logic fill_en,
	output fetch_geom_pkg::addr_t fill_addr
);

	import fetch_geom_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic [1:0] {
		idle,
		request,
		wait_fill
	} miss_state_t;

	miss_state_t state;
	miss_state_t next_state;

	// block address of the outstanding miss
	addr_t miss_addr;
	// tag memory gave back when it took the load
	mem_tag_t miss_tag;

	logic start_miss;
	logic accepted;
	logic tag_match;

	////////////////////////////////////////////////////////////////////////////
	// handshake decode
	////////////////////////////////////////////////////////////////////////////

	// a redirect this cycle means the pc is about to change, skip it
	assign start_miss = (state == idle) && !hit && !redirect;
	// nonzero response names the tag
	assign accepted = (state == request) && (mem_response != no_tag);
	// other tags belong to nobody here
	assign tag_match = (state == wait_fill) && (mem_tag == miss_tag) && (mem_tag != no_tag);

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (start_miss) begin
					next_state = request;
				end
			end
			request: begin
				// refused, try again next cycle
				if (accepted) begin
					next_state = wait_fill;
				end
			end
			wait_fill: begin
				// redirect does not cancel, the fill still lands
				if (tag_match) begin
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// miss payload, only meaningful outside idle
	always_ff @(posedge clock) begin
		if (start_miss) begin
			miss_addr <= {lookup_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
		end
		if (accepted) begin
			miss_tag <= mem_response;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	// same address held for every retry
	assign mem_command = (state == request) ? cmd_load : cmd_none;
	assign mem_addr = miss_addr;
	assign fill_en = tag_match;
	assign fill_addr = miss_addr;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a load only follows a detected miss or a refused load
	load_after_miss: assert property (
		@(posedge clock) disable iff (reset)
		mem_command == cmd_load |-> $past(state) inside {idle, request}
	) else $error("load issued without a miss");

	// a fill only follows an accepted request
	fill_after_accept: assert property (
		@(posedge clock) disable iff (reset)
		fill_en |-> state == wait_fill && $past(state) inside {request, wait_fill}
	) else $error("fill without an accepted load");

endmodule

// File: logic/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch front end
// pc counter, cache lines and miss controller joined to the memory bus
// and to the fetch port; the consumer sees one 64-bit block per hit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit (
	input logic clock,
	input logic reset,
	// back end control
	input logic stall,
	input logic redirect,
	input fetch_geom_pkg::addr_t redirect_pc,
	// memory replies
	input mem_bus_pkg::mem_tag_t mem_response,
	input mem_bus_pkg::mem_tag_t mem_tag,
	input fetch_geom_pkg::block_t mem_data,
	// memory requests
	output mem_bus_pkg::mem_cmd_t mem_command,
	output fetch_geom_pkg::addr_t mem_addr,
	// fetch port
	output fetch_geom_pkg::addr_t fetch_pc,
	output fetch_geom_pkg::block_t fetch_block,
	output logic fetch_valid
);

	import fetch_geom_pkg::*;
	import mem_bus_pkg::*;

	// miss controller to cache write port
	logic fill_en;
	addr_t fill_addr;

	// pc steps on hit, so fetch_valid doubles as the hit
	fetch_pc_counter u_pc (
		.clock(clock),
		.reset(reset),
		.hit(fetch_valid),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.pc(fetch_pc)
	);

	// fill data straight from the bus
	icache_lines u_lines (
		.clock(clock),
		.reset(reset),
		.lookup_addr(fetch_pc),
		.fill_en(fill_en),
		.fill_addr(fill_addr),
		.fill_block(mem_data),
		.hit(fetch_valid),
		.lookup_block(fetch_block)
	);

	icache_miss_fsm u_miss (
		.clock(clock),
		.reset(reset),
		.lookup_addr(fetch_pc),
		.hit(fetch_valid),
		.redirect(redirect),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.fill_en(fill_en),
		.fill_addr(fill_addr)
	);

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// refused load comes back unchanged on the next cycle
	retry_same_addr: assert property (
		@(posedge clock) disable iff (reset)
		mem_command == cmd_load && mem_response == no_tag
		|=> mem_command == cmd_load && $stable(mem_addr)
	) else $error("refused load not repeated at %h", $past(mem_addr));

endmodule

// File: tests/tb_clock.sv
////////////////////////////////////////////////////////////////////////////
// free running testbench clock, 100 ns period, starts low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
	output logic clock
);

	// half of the 100 ns period
	localparam int half_period = 50;

	initial begin
		clock = 1'b0;
	end

	always begin
		#(half_period) clock = ~clock;
	end

endmodule

// File: tests/fetch_checker.sv
////////////////////////////////////////////////////////////////////////////
// fetch unit checker for the testbench
// samples the DUT on every rising edge, predicts the fetch pc from the
// redirects it sees, checks block data, stall holds and load retries
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_checker (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic redirect,
	input fetch_geom_pkg::addr_t redirect_pc,
	input mem_bus_pkg::mem_cmd_t mem_command,
	input mem_bus_pkg::mem_tag_t mem_response,
	input fetch_geom_pkg::addr_t mem_addr,
	input fetch_geom_pkg::addr_t fetch_pc,
	input fetch_geom_pkg::block_t fetch_block,
	input logic fetch_valid,
	// end of one table entry
	input logic entry_done,
	input int entry_index,
	output int error_count,
	output int block_count,
	output int refusal_count
);

	import fetch_geom_pkg::*;
	import mem_bus_pkg::*;

	// running totals
	int errors = 0;
	int blocks = 0;
	int refusals = 0;
	int entry_errors = 0;
	int entry_blocks = 0;

	// predicted pc is the aligned target plus one step per accepted block
	addr_t exp_pc = reset_pc;
	addr_t entry_target = reset_pc;
	logic after_reset = 1'b0;
	// stalled hit seen last edge
	logic hold_check = 1'b0;
	addr_t held_pc = '0;
	block_t held_block = '0;
	// refused load seen last edge
	logic retry_check = 1'b0;
	addr_t retry_addr = '0;

	assign error_count = errors;
	assign block_count = blocks;
	assign refusal_count = refusals;

	// memory contents by block address
	function automatic block_t expected_block(input addr_t a);
		return {a ^ 32'h1357_9bdf, a};
	endfunction

	function automatic addr_t block_align(input addr_t a);
		return a & ~(block_bytes - 32'd1);
	endfunction

	task automatic note_error();
		errors = errors + 1;
		entry_errors = entry_errors + 1;
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
			note_error();
		end
	endtask

	task automatic check_block(input string name, input block_t expected, input block_t actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
			note_error();
		end
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		note_error();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per edge checks
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			after_reset = 1'b1;
			hold_check = 1'b0;
			retry_check = 1'b0;
			exp_pc = reset_pc;
		end else begin
			// first cycle out of reset expects an empty cache and a quiet bus
			if (after_reset) begin
				if (fetch_valid !== 1'b0) begin
					$display("ERR %0t fetch_valid expected 0 got %b", $time, fetch_valid);
					note_error();
				end
				check_addr("fetch_pc", reset_pc, fetch_pc);
				if (mem_command != cmd_none) begin
					report_failure("memory command active right after reset");
				end
				after_reset = 1'b0;
			end
			// entry summary before this cycle's accept
			if (entry_done) begin
				$display("entry %0d at %h: %0d blocks checked, %0d errors",
					entry_index, entry_target, entry_blocks, entry_errors);
				entry_blocks = 0;
				entry_errors = 0;
			end
			if (hold_check) begin
				check_addr("fetch_pc", held_pc, fetch_pc);
				// a fill of another block may evict the line
				if (fetch_valid) begin
					check_block("fetch_block", held_block, fetch_block);
				end
			end
			if (retry_check) begin
				if (mem_command != cmd_load) begin
					report_failure("refused load was not repeated on the next cycle");
				end
				check_addr("mem_addr", retry_addr, mem_addr);
			end
			// pc prediction and data rule
			if (redirect) begin
				exp_pc = block_align(redirect_pc);
				entry_target = exp_pc;
			end else if (fetch_valid && !stall) begin
				check_addr("fetch_pc", exp_pc, fetch_pc);
				check_block("fetch_block", expected_block(exp_pc), fetch_block);
				exp_pc = exp_pc + block_bytes;
				blocks = blocks + 1;
				entry_blocks = entry_blocks + 1;
			end
			hold_check = fetch_valid && stall && !redirect;
			held_pc = fetch_pc;
			held_block = fetch_block;
			retry_check = (mem_command == cmd_load) && (mem_response == no_tag);
			retry_addr = mem_addr;
			if (retry_check) begin
				refusals = refusals + 1;
			end
		end
	end

endmodule

// File: tests/fetch_unit_tb.sv
////////////////////////////////////////////////////////////////////////////
// fetch unit testbench top
// drives redirects and stalls from a table, models tagged memory with
// random refusals and latency, and ends on the checker's error count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_unit_tb;

	import fetch_geom_pkg::*;
	import mem_bus_pkg::*;

	localparam int num_entries = 9;
	localparam int cycles_per_block = 200;

	////////////////////////////////////////////////////////////////////////////
	// stimulus table, redirect target, blocks to accept, stall percent
	////////////////////////////////////////////////////////////////////////////

	// cold run, second pass, odd target, mid miss redirect,
	// 0x40 and 0x140 share index 8, then an index wrap
	localparam addr_t entry_addr [num_entries] = '{
		32'h0000_0000, 32'h0000_0000, 32'h0000_0203,
		32'h0000_1000, 32'h0000_0040, 32'h0000_0140,
		32'h0000_0040, 32'h0000_0140, 32'h0000_2ff8
	};
	localparam int entry_blocks [num_entries] = '{12, 12, 6, 0, 1, 1, 1, 1, 8};
	localparam int entry_stall [num_entries] = '{0, 30, 50, 0, 20, 20, 0, 0, 40};

	logic clock;
	logic reset = 1'b1;
	logic stall = 1'b0;
	logic redirect = 1'b0;
	addr_t redirect_pc = '0;
	mem_tag_t mem_response = no_tag;
	mem_tag_t mem_tag = no_tag;
	block_t mem_data = '0;
	mem_cmd_t mem_command;
	addr_t mem_addr;
	addr_t fetch_pc;
	block_t fetch_block;
	logic fetch_valid;

	logic entry_done = 1'b0;
	int entry_index = 0;
	int error_count;
	int block_count;
	int refusal_count;
	int cycle_count = 0;
	int timeout_limit;

	// separate streams, stimulus and memory draws never interleave
	integer stall_seed = 32'h81f0_a9e9;
	integer mem_seed = 32'h81f0_a9e9;

	tb_clock u_clock (.clock(clock));

	fetch_unit u_fetch_unit (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_data(mem_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.fetch_pc(fetch_pc),
		.fetch_block(fetch_block),
		.fetch_valid(fetch_valid)
	);

	fetch_checker u_checker (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.mem_command(mem_command),
		.mem_response(mem_response),
		.mem_addr(mem_addr),
		.fetch_pc(fetch_pc),
		.fetch_block(fetch_block),
		.fetch_valid(fetch_valid),
		.entry_done(entry_done),
		.entry_index(entry_index),
		.error_count(error_count),
		.block_count(block_count),
		.refusal_count(refusal_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////////////////////

	mem_tag_t next_tag = 4'd1;
	logic pend_valid = 1'b0;
	mem_tag_t pend_tag = no_tag;
	addr_t pend_addr = '0;
	int pend_wait = 0;

	// upper half scrambled, lower half the block address itself
	function automatic block_t memory_block(input addr_t a);
		return {a ^ 32'h1357_9bdf, a};
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			next_tag = 4'd1;
			pend_valid = 1'b0;
			mem_response <= no_tag;
			mem_tag <= no_tag;
		end else begin
			// data goes out for one cycle when the delay runs out
			if (pend_valid && pend_wait == 1) begin
				mem_tag <= pend_tag;
				mem_data <= memory_block(pend_addr);
				pend_valid = 1'b0;
			end else begin
				mem_tag <= no_tag;
				mem_data <= {$random(mem_seed), $random(mem_seed)};
				if (pend_valid) begin
					pend_wait = pend_wait - 1;
				end
			end
			// load taken in the cycle just ended
			if (mem_command == cmd_load && mem_response != no_tag) begin
				pend_valid = 1'b1;
				pend_tag = mem_response;
				pend_addr = mem_addr;
				pend_wait = 2 + int'($unsigned($random(mem_seed)) % 5);
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// answer for next cycle, about one in four refused
			if ($unsigned($random(mem_seed)) % 4 == 0) begin
				mem_response <= no_tag;
			end else begin
				mem_response <= next_tag;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic logic roll_stall(input int density);
		return int'($unsigned($random(stall_seed)) % 100) < density;
	endfunction

	function automatic int total_blocks();
		int sum;
		sum = 0;
		for (int i = 0; i < num_entries; i++) begin
			sum += entry_blocks[i];
		end
		return sum;
	endfunction

	// one redirect, then wait for the table's count of accepted blocks
	task automatic run_entry(input int i);
		int accepted;
		accepted = 0;
		@(posedge clock);
		entry_done <= 1'b0;
		redirect <= 1'b1;
		redirect_pc <= entry_addr[i];
		stall <= roll_stall(entry_stall[i]);
		@(posedge clock);
		redirect <= 1'b0;
		stall <= roll_stall(entry_stall[i]);
		while (accepted < entry_blocks[i]) begin
			@(posedge clock);
			if (fetch_valid && !stall) begin
				accepted++;
			end
			stall <= roll_stall(entry_stall[i]);
		end
		entry_index <= i;
		entry_done <= 1'b1;
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout after %0d cycles, fetched blocks did not arrive", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		timeout_limit = cycles_per_block * total_blocks();
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < num_entries; i++) begin
			run_entry(i);
		end
		@(posedge clock);
		entry_done <= 1'b0;
		repeat (2) @(posedge clock);
		$display("totals: %0d blocks checked, %0d loads refused, %0d errors",
			block_count, refusal_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: fetch_unit.f
logic/fetch_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/fetch_pc_counter.sv
logic/icache_lines.sv
logic/icache_miss_fsm.sv
logic/fetch_unit.sv
tests/tb_clock.sv
tests/fetch_checker.sv
tests/fetch_unit_tb.sv

// File: run.sh
#!/bin/sh
# builds the fetch unit testbench with Verilator, runs it, and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module fetch_unit_tb \
	-f fetch_unit.f \
	-o fetch_unit_sim

./obj_dir/fetch_unit_sim > sim.log 2>&1
cat sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
